/* mem_cfg_pkg.sv */
package mem_cfg_pkg;

  // Memory geometry of the data-cursor controller
  localparam int ADDR_WIDTH = 16;
  localparam int WORD_WIDTH = 32;

  // dc0 is the main cursor and dc1 to dc3 are reloaded in the background
  localparam int DC_COUNT = 4;

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Index of one data cursor
  typedef logic [1:0] dc_sel_t;

  // One cycle's request to the single-cycle memory port.
  // A write and a read may both be issued in the same cycle
  typedef struct packed {
    logic    write_out;
    addr_t   write_address;
    word_t   write_value;
    addr_t   read_address;
    // The read result is routed back into the cursor named by choice
    logic    reload;
    dc_sel_t choice;
  } mem_req_t;

endpackage

/* mem_isa_pkg.sv */
package mem_isa_pkg;

  // Opcodes that carry a cursor index use the low two bits for it
  localparam logic [7:0] OPC_NOP        = 8'h00;
  localparam logic [7:0] OPC_READ_BASE  = 8'h10;
  localparam logic [7:0] OPC_WRITE_BASE = 8'h20;
  localparam logic [7:0] OPC_SETF_BASE  = 8'h30;
  localparam logic [7:0] OPC_SETB_BASE  = 8'h34;
  localparam logic [7:0] OPC_WRITE_TOP  = 8'h40;

  // What the execute stage has to do with the cursors this cycle
  typedef enum logic [2:0] {
    OP_NOP,
    OP_READ,
    OP_WRITE_DC,
    OP_SETF,
    OP_SETB,
    OP_WRITE_TOP
  } op_kind_e;

  // Decoded instruction handed from decode to execute
  typedef struct packed {
    op_kind_e            kind;
    mem_cfg_pkg::dc_sel_t sel;
  } decoded_t;

endpackage

/* dc_if.sv */
`timescale 1ns/1ps

interface dc_if;

  // Current cursor state as held in the register file
  mem_cfg_pkg::addr_t [mem_cfg_pkg::DC_COUNT-1:0] addrs;
  logic [mem_cfg_pkg::DC_COUNT-1:0] dirs;
  // dc0 is always loaded so it has no bit here
  logic [mem_cfg_pkg::DC_COUNT-1:1] loadeds;

  // Cursor state proposed by the execute stage
  mem_cfg_pkg::addr_t [mem_cfg_pkg::DC_COUNT-1:0] next_addrs;
  logic [mem_cfg_pkg::DC_COUNT-1:0] next_dirs;
  logic [mem_cfg_pkg::DC_COUNT-1:1] next_loadeds;

  // High when the instruction won arbitration and its state may be taken
  logic commit;

  modport file (
    output addrs, dirs, loadeds,
    input  next_addrs, next_dirs, next_loadeds, commit
  );

  modport exec (
    input  addrs, dirs, loadeds,
    output next_addrs, next_dirs, next_loadeds
  );

  modport result (output commit);

endinterface

/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
  input  logic [7:0]            instruction,
  output mem_isa_pkg::decoded_t decoded
);

  import mem_cfg_pkg::*;
  import mem_isa_pkg::*;

  always_comb begin
    // The cursor index sits in the low two bits for every indexed opcode
    decoded.sel  = dc_sel_t'(instruction[1:0]);
    decoded.kind = OP_NOP;

    if (instruction == OPC_NOP) begin
      decoded.kind = OP_NOP;
    end else if (instruction == OPC_WRITE_TOP) begin
      decoded.kind = OP_WRITE_TOP;
    end else begin
      // Match the upper six bits against the opcode groups
      case (instruction[7:2])
        OPC_READ_BASE[7:2]: begin
          decoded.kind = OP_READ;
        end
        OPC_WRITE_BASE[7:2]: begin
          decoded.kind = OP_WRITE_DC;
        end
        OPC_SETF_BASE[7:2]: begin
          decoded.kind = OP_SETF;
        end
        OPC_SETB_BASE[7:2]: begin
          decoded.kind = OP_SETB;
        end
        default: begin
          // Anything not in the instruction set behaves as a NOP
          decoded.kind = OP_NOP;
        end
      endcase
    end
  end

endmodule

/* dc_execute.sv */
`timescale 1ns/1ps

module dc_execute (
  input  mem_isa_pkg::decoded_t decoded,
  input  mem_cfg_pkg::word_t    top,
  input  mem_cfg_pkg::word_t    second,
  dc_if.exec                    dc,
  output mem_cfg_pkg::mem_req_t req
);

  import mem_cfg_pkg::*;
  import mem_isa_pkg::*;

  // Background reloader result
  logic    reload_found;
  dc_sel_t reload_pick;

  // Per-cursor advanced addresses for reads and for direction-aware writes
  addr_t [DC_COUNT-1:0] read_adv;
  addr_t [DC_COUNT-1:0] write_adv;

  // Address that SETF and SETB load into a cursor
  addr_t set_value;

  assign set_value = top[ADDR_WIDTH-1:0];

  always_comb begin
    for (int i = 0; i < DC_COUNT; i++) begin
      read_adv[i]  = dc.addrs[i] + addr_t'(1);
      write_adv[i] = dc.dirs[i] ? dc.addrs[i] - addr_t'(1) : dc.addrs[i] + addr_t'(1);
    end
  end

  // Pick the lowest-index unloaded cursor among 1 to 3
  // The scan runs high to low so the lowest one is assigned last
  always_comb begin
    reload_found = 1'b0;
    reload_pick  = '0;
    for (int i = DC_COUNT - 1; i >= 1; i--) begin
      if (!dc.loadeds[i]) begin
        reload_found = 1'b1;
        reload_pick  = dc_sel_t'(i);
      end
    end
  end

  always_comb begin
    dc.next_addrs   = dc.addrs;
    dc.next_dirs    = dc.dirs;
    dc.next_loadeds = dc.loadeds;

    req.write_out     = 1'b0;
    req.write_address = '0;
    req.write_value   = '0;
    req.read_address  = '0;
    req.reload        = 1'b1;
    req.choice        = decoded.sel;

    case (decoded.kind)
      OP_READ: begin
        dc.next_addrs[decoded.sel] = read_adv[decoded.sel];
        req.read_address           = read_adv[decoded.sel];
      end
      OP_WRITE_DC: begin
        // Post-increment writes the old address and pre-decrement writes the new one
        dc.next_addrs[decoded.sel] = write_adv[decoded.sel];
        req.write_out              = 1'b1;
        req.write_address          = dc.dirs[decoded.sel] ? write_adv[decoded.sel]
                                                          : dc.addrs[decoded.sel];
        req.write_value            = top;
        req.read_address           = write_adv[decoded.sel];
      end
      OP_SETF, OP_SETB: begin
        dc.next_addrs[decoded.sel] = set_value;
        dc.next_dirs[decoded.sel]  = (decoded.kind == OP_SETB);
        req.read_address           = set_value;
        // A freshly set cursor waits for the reloader before it counts as loaded
        if (decoded.sel != 2'd0) begin
          dc.next_loadeds[decoded.sel] = 1'b0;
        end
      end
      default: begin
        // NOP and WRITE spend the read port on the background reloader
        if (reload_found) begin
          req.read_address              = dc.addrs[reload_pick];
          req.reload                    = 1'b1;
          req.choice                    = reload_pick;
          dc.next_loadeds[reload_pick]  = 1'b1;
        end else begin
          req.reload = 1'b0;
          req.choice = '0;
        end
        if (decoded.kind == OP_WRITE_TOP) begin
          req.write_out     = 1'b1;
          req.write_address = top[ADDR_WIDTH-1:0];
          req.write_value   = second;
        end
      end
    endcase
  end

endmodule

/* dc_file.sv */
`timescale 1ns/1ps

module dc_file (
  input  logic               clk,
  input  logic               reset,
  dc_if.file                 dc,
  input  logic               int_load,
  input  mem_cfg_pkg::addr_t int_dc0
);

  import mem_cfg_pkg::*;

  addr_t [DC_COUNT-1:0] addrs_q;
  logic  [DC_COUNT-1:0] dirs_q;
  logic  [DC_COUNT-1:1] loadeds_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      addrs_q   <= '0;
      dirs_q    <= '0;
      loadeds_q <= '0;
    end else if (dc.commit) begin
      addrs_q   <= dc.next_addrs;
      dirs_q    <= dc.next_dirs;
      loadeds_q <= dc.next_loadeds;
    end else if (int_load) begin
      // The interrupt vector only moves dc0 and the other cursors stay as they are
      addrs_q[0] <= int_dc0;
    end
  end

  assign dc.addrs   = addrs_q;
  assign dc.dirs    = dirs_q;
  assign dc.loadeds = loadeds_q;

endmodule

/* mem_result.sv */
`timescale 1ns/1ps

module mem_result (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  handle_interrupt,
  input  logic                  stream_in,
  input  logic                  stream_out,
  input  mem_cfg_pkg::word_t    stream_in_value,
  input  mem_cfg_pkg::addr_t    stream_address,
  input  mem_cfg_pkg::addr_t    interrupt_dc0,
  input  mem_cfg_pkg::mem_req_t req,
  dc_if.result                  dc,
  output logic                  int_load,
  output mem_cfg_pkg::mem_req_t out_req
);

  import mem_cfg_pkg::*;

  mem_req_t win;

  // Any interrupt or stream preempts the instruction and its cursor update
  assign dc.commit = !(handle_interrupt || stream_in || stream_out);
  assign int_load  = handle_interrupt;

  always_comb begin
    win = req;
    if (handle_interrupt) begin
      win.write_out    = 1'b0;
      win.read_address = interrupt_dc0;
      win.reload       = 1'b1;
      win.choice       = '0;
    end else if (stream_in) begin
      win.write_out     = 1'b1;
      win.write_address = stream_address;
      win.write_value   = stream_in_value;
      win.read_address  = '0;
      win.reload        = 1'b0;
      win.choice        = '0;
    end else if (stream_out) begin
      win.write_out    = 1'b0;
      win.read_address = stream_address;
      win.reload       = 1'b0;
      win.choice       = '0;
    end
  end

  always_ff @(posedge clk) begin
    out_req.write_address <= win.write_address;
    out_req.write_value   <= win.write_value;
    if (reset) begin
      out_req.write_out    <= 1'b0;
      out_req.read_address <= '0;
      out_req.reload       <= 1'b0;
      out_req.choice       <= '0;
    end else begin
      out_req.write_out    <= win.write_out;
      out_req.read_address <= win.read_address;
      out_req.reload       <= win.reload;
      out_req.choice       <= win.choice;
    end
  end

endmodule

/* mem_control.sv */
`timescale 1ns/1ps

module mem_control (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           instruction,
  input  mem_cfg_pkg::word_t   top,
  input  mem_cfg_pkg::word_t   second,
  input  mem_cfg_pkg::word_t   stream_in_value,
  input  logic                 handle_interrupt,
  input  logic                 stream_in,
  input  logic                 stream_out,
  input  mem_cfg_pkg::addr_t   stream_address,
  input  mem_cfg_pkg::addr_t   interrupt_dc0,
  output logic                 write_out,
  output mem_cfg_pkg::addr_t   write_address,
  output mem_cfg_pkg::word_t   write_value,
  output mem_cfg_pkg::addr_t   read_address,
  output logic                 reload,
  output mem_cfg_pkg::dc_sel_t choice
);

  import mem_cfg_pkg::*;

  mem_isa_pkg::decoded_t decoded;
  mem_req_t              exec_req;
  mem_req_t              out_req;
  logic                  int_load;

  dc_if dc_bus ();

  instr_decode instr_decode_inst (
    .instruction (instruction),
    .decoded     (decoded)
  );

  dc_execute dc_execute_inst (
    .decoded (decoded),
    .top     (top),
    .second  (second),
    .dc      (dc_bus.exec),
    .req     (exec_req)
  );

  dc_file dc_file_inst (
    .clk      (clk),
    .reset    (reset),
    .dc       (dc_bus.file),
    .int_load (int_load),
    .int_dc0  (interrupt_dc0)
  );

  mem_result mem_result_inst (
    .clk              (clk),
    .reset            (reset),
    .handle_interrupt (handle_interrupt),
    .stream_in        (stream_in),
    .stream_out       (stream_out),
    .stream_in_value  (stream_in_value),
    .stream_address   (stream_address),
    .interrupt_dc0    (interrupt_dc0),
    .req              (exec_req),
    .dc               (dc_bus.result),
    .int_load         (int_load),
    .out_req          (out_req)
  );

  assign write_out     = out_req.write_out;
  assign write_address = out_req.write_address;
  assign write_value   = out_req.write_value;
  assign read_address  = out_req.read_address;
  assign reload        = out_req.reload;
  assign choice        = out_req.choice;

endmodule

/* tb_mem_vectors.svh */
`ifndef TB_MEM_VECTORS_SVH
`define TB_MEM_VECTORS_SVH

// Each row holds instruction, handle_interrupt, stream_in, stream_out,
// stream_address, stream_in_value and interrupt_dc0 in that order
typedef struct packed {
  logic [7:0] instruction;
  logic       handle_interrupt;
  logic       stream_in;
  logic       stream_out;
  addr_t      stream_address;
  word_t      stream_in_value;
  addr_t      interrupt_dc0;
} vec_t;

localparam int VEC_COUNT = 30;

// One pair of top and second words per row comes from $urandom
vec_t vectors [VEC_COUNT] = '{
  // Background reload walks cursors 1 to 3 and then has nothing left to do
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // SETF2, WRITE2 twice, SETB2, WRITE2
  {8'h32, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h22, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h22, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h36, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h22, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // READ0 three times
  {8'h10, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h10, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h10, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // SETF1 unloads cursor 1 and the NOP after it reloads it
  {8'h31, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // WRITE picks up cursor 2 that SETF2 and SETB2 left unloaded
  {8'h40, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // Preempted SETF3 and READ1 must leave the cursors alone
  {8'h33, 1'b0, 1'b1, 1'b0, 16'h0200, 32'hcafe_0016, 16'h0000},
  {8'h00, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h11, 1'b0, 1'b0, 1'b1, 16'h0300, 32'h0000_0000, 16'h0000},
  {8'h11, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // Interrupt moves dc0 and READ0 continues from the vector
  {8'h10, 1'b1, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0800},
  {8'h10, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h10, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // Unknown opcode behaves as a NOP
  {8'hff, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // SETB0 then a pre-decrement WRITE0
  {8'h34, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h20, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  // Priority between simultaneous requests
  {8'h00, 1'b0, 1'b1, 1'b1, 16'h0400, 32'h1234_5678, 16'h0000},
  {8'h21, 1'b1, 1'b1, 1'b0, 16'h0500, 32'h5555_aaaa, 16'h0c00},
  {8'h10, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000},
  {8'h40, 1'b0, 1'b0, 1'b0, 16'h0000, 32'h0000_0000, 16'h0000}
};

`endif

/* tb_mem_control.sv */
`timescale 1ns/1ps

module tb_mem_control;

  import mem_cfg_pkg::*;
  import mem_isa_pkg::*;

  localparam int WATCHDOG_CYCLES = 200;
  localparam int RESET_TIMEOUT   = 10;

  logic       clk;
  logic       reset;
  logic [7:0] instruction;
  word_t      top;
  word_t      second;
  word_t      stream_in_value;
  logic       handle_interrupt;
  logic       stream_in;
  logic       stream_out;
  addr_t      stream_address;
  addr_t      interrupt_dc0;
  logic       write_out;
  addr_t      write_address;
  word_t      write_value;
  addr_t      read_address;
  logic       reload;
  dc_sel_t    choice;

  `include "tb_mem_vectors.svh"

  word_t top_vals [VEC_COUNT];
  word_t second_vals [VEC_COUNT];

  // Reference copy of the cursor state
  // Index 0 of m_loaded is unused
  addr_t m_addr [DC_COUNT];
  logic  m_dir [DC_COUNT];
  logic  m_loaded [DC_COUNT];

  mem_control mem_control_inst (
    .clk              (clk),
    .reset            (reset),
    .instruction      (instruction),
    .top              (top),
    .second           (second),
    .stream_in_value  (stream_in_value),
    .handle_interrupt (handle_interrupt),
    .stream_in        (stream_in),
    .stream_out       (stream_out),
    .stream_address   (stream_address),
    .interrupt_dc0    (interrupt_dc0),
    .write_out        (write_out),
    .write_address    (write_address),
    .write_value      (write_value),
    .read_address     (read_address),
    .reload           (reload),
    .choice           (choice)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (3) @(posedge clk);
    reset <= 1'b0;
  end

  initial begin
    for (int c = 0; c < WATCHDOG_CYCLES; c++) begin
      @(posedge clk);
    end
    $display("timeout: the vector table did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped after the first failure");
  endtask

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    $display("error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    abort_run();
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      report_mismatch(name, word_t'(expected), word_t'(actual));
    end
  endtask

  task automatic check_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_mismatch(name, expected, actual);
    end
  endtask

  task automatic check_req(input mem_req_t expected, input mem_req_t actual);
    if (actual.write_out !== expected.write_out) begin
      report_mismatch("write_out", word_t'(expected.write_out), word_t'(actual.write_out));
    end
    // The write payload only means something while write_out is high
    if (expected.write_out) begin
      check_addr("write_address", expected.write_address, actual.write_address);
      check_word("write_value", expected.write_value, actual.write_value);
    end
    check_addr("read_address", expected.read_address, actual.read_address);
    if (actual.reload !== expected.reload) begin
      report_mismatch("reload", word_t'(expected.reload), word_t'(actual.reload));
    end
    if (actual.choice !== expected.choice) begin
      report_mismatch("choice", word_t'(expected.choice), word_t'(actual.choice));
    end
  endtask

  function automatic mem_req_t sample_outputs();
    mem_req_t r;
    r.write_out     = write_out;
    r.write_address = write_address;
    r.write_value   = write_value;
    r.read_address  = read_address;
    r.reload        = reload;
    r.choice        = choice;
    return r;
  endfunction

  function automatic op_kind_e opcode_kind(input logic [7:0] opc);
    if (opc == OPC_WRITE_TOP) begin
      return OP_WRITE_TOP;
    end
    case (opc & 8'hfc)
      OPC_READ_BASE:  return OP_READ;
      OPC_WRITE_BASE: return OP_WRITE_DC;
      OPC_SETF_BASE:  return OP_SETF;
      OPC_SETB_BASE:  return OP_SETB;
      default:        return OP_NOP;
    endcase
  endfunction

  // Expected request for one row
  // The mirrored cursor state moves along with it
  task automatic model_step(input vec_t v, input word_t t, input word_t s,
                            output mem_req_t expected);
    dc_sel_t  k;
    op_kind_e kind;
    logic     found;
    dc_sel_t  pick;
    expected = '0;
    k        = v.instruction[1:0];
    kind     = opcode_kind(v.instruction);
    found    = 1'b0;
    pick     = '0;
    if (v.handle_interrupt) begin
      expected.read_address = v.interrupt_dc0;
      expected.reload       = 1'b1;
      m_addr[0]             = v.interrupt_dc0;
    end else if (v.stream_in) begin
      expected.write_out     = 1'b1;
      expected.write_address = v.stream_address;
      expected.write_value   = v.stream_in_value;
    end else if (v.stream_out) begin
      expected.read_address = v.stream_address;
    end else begin
      case (kind)
        OP_READ: begin
          m_addr[k]             = m_addr[k] + 1'b1;
          expected.read_address = m_addr[k];
          expected.reload       = 1'b1;
          expected.choice       = k;
        end
        OP_WRITE_DC: begin
          expected.write_out   = 1'b1;
          expected.write_value = t;
          if (m_dir[k]) begin
            m_addr[k]              = m_addr[k] - 1'b1;
            expected.write_address = m_addr[k];
          end else begin
            expected.write_address = m_addr[k];
            m_addr[k]              = m_addr[k] + 1'b1;
          end
          expected.read_address = m_addr[k];
          expected.reload       = 1'b1;
          expected.choice       = k;
        end
        OP_SETF, OP_SETB: begin
          m_addr[k] = t[ADDR_WIDTH-1:0];
          m_dir[k]  = (kind == OP_SETB);
          if (k != 2'd0) begin
            m_loaded[k] = 1'b0;
          end
          expected.read_address = m_addr[k];
          expected.reload       = 1'b1;
          expected.choice       = k;
        end
        default: begin
          for (int j = 1; j < DC_COUNT; j++) begin
            if (!found && !m_loaded[j]) begin
              found = 1'b1;
              pick  = dc_sel_t'(j);
            end
          end
          if (found) begin
            expected.read_address = m_addr[pick];
            expected.reload       = 1'b1;
            expected.choice       = pick;
            m_loaded[pick]        = 1'b1;
          end
          if (kind == OP_WRITE_TOP) begin
            expected.write_out     = 1'b1;
            expected.write_address = t[ADDR_WIDTH-1:0];
            expected.write_value   = s;
          end
        end
      endcase
    end
  endtask

  task automatic apply_row(input vec_t v, input word_t t, input word_t s);
    instruction      <= v.instruction;
    handle_interrupt <= v.handle_interrupt;
    stream_in        <= v.stream_in;
    stream_out       <= v.stream_out;
    stream_address   <= v.stream_address;
    stream_in_value  <= v.stream_in_value;
    interrupt_dc0    <= v.interrupt_dc0;
    top              <= t;
    second           <= s;
  endtask

  // A stream read of address 0 keeps every cursor where it is
  task automatic apply_idle();
    instruction      <= OPC_NOP;
    handle_interrupt <= 1'b0;
    stream_in        <= 1'b0;
    stream_out       <= 1'b1;
    stream_address   <= '0;
    stream_in_value  <= '0;
    interrupt_dc0    <= '0;
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (reset) begin
      @(negedge clk);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        $display("timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
        abort_run();
      end
    end
  endtask

  initial begin
    int       seed;
    mem_req_t expected;
    seed = 32'hd9c8_5b10;
    void'($urandom(seed));

    reset            = 1'b1;
    instruction      = OPC_NOP;
    top              = '0;
    second           = '0;
    stream_in_value  = '0;
    handle_interrupt = 1'b0;
    stream_in        = 1'b0;
    stream_out       = 1'b1;
    stream_address   = '0;
    interrupt_dc0    = '0;

    for (int i = 0; i < VEC_COUNT; i++) begin
      top_vals[i]    = $urandom();
      second_vals[i] = $urandom();
    end
    for (int i = 0; i < DC_COUNT; i++) begin
      m_addr[i]   = '0;
      m_dir[i]    = 1'b0;
      m_loaded[i] = 1'b0;
    end

    wait_reset_release();
    expected = '0;
    check_req(expected, sample_outputs());

    @(posedge clk);
    apply_row(vectors[0], top_vals[0], second_vals[0]);
    for (int i = 0; i < VEC_COUNT; i++) begin
      @(posedge clk);
      if (i + 1 < VEC_COUNT) begin
        apply_row(vectors[i+1], top_vals[i+1], second_vals[i+1]);
      end else begin
        apply_idle();
      end
      // Row i was taken at this edge and its registered result is stable by the falling edge
      @(negedge clk);
      model_step(vectors[i], top_vals[i], second_vals[i], expected);
      check_req(expected, sample_outputs());
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
mem_cfg_pkg.sv
mem_isa_pkg.sv
dc_if.sv
instr_decode.sv
dc_execute.sv
dc_file.sv
mem_result.sv
mem_control.sv
tb_mem_control.sv
